/* dbg_pkg.sv */
// Debug subsystem shared definitions
// Widths, DMI register map, field positions and common types
package dbg_pkg;

	localparam int N_HARTS = 2;
	localparam int XLEN    = 32;
	localparam int DMI_AW  = 7;

	typedef logic [XLEN-1:0]            word_t;
	typedef logic [DMI_AW-1:0]          dmi_addr_t;
	typedef logic [$clog2(N_HARTS)-1:0] hart_sel_t;
	typedef logic [2:0]                 sberr_t;

	// DMI register map
	localparam dmi_addr_t ADDR_DATA0      = 7'h04;
	localparam dmi_addr_t ADDR_DMCONTROL  = 7'h10;
	localparam dmi_addr_t ADDR_DMSTATUS   = 7'h11;
	localparam dmi_addr_t ADDR_SBCS       = 7'h38;
	localparam dmi_addr_t ADDR_SBADDRESS0 = 7'h39;
	localparam dmi_addr_t ADDR_SBDATA0    = 7'h3c;

	// dmcontrol
	localparam int DMC_HALTREQ   = 31;
	localparam int DMC_RESUMEREQ = 30;
	localparam int DMC_HARTSEL   = 16;
	localparam int DMC_NDMRESET  = 1;
	localparam int DMC_DMACTIVE  = 0;

	// dmstatus
	localparam int DMS_ALLRUNNING    = 11;
	localparam int DMS_ANYRUNNING    = 10;
	localparam int DMS_ALLHALTED     = 9;
	localparam int DMS_ANYHALTED     = 8;
	localparam int DMS_AUTHENTICATED = 7;
	localparam int DMS_VERSION       = 0;

	// sbcs, sberror occupies bits 14:12
	localparam int SBCS_SBBUSY       = 21;
	localparam int SBCS_AUTOINC      = 16;
	localparam int SBCS_READONDATA   = 15;
	localparam int SBCS_SBERROR      = 12;

	localparam logic [3:0] DM_VERSION = 4'd2;
	localparam sberr_t     SBERR_BUS  = 3'd2;

endpackage

/* hart_dbg_if.sv */
// Per-hart debug channel between the debug module and a hart agent
`timescale 1ns/100ps

interface hart_dbg_if;
	import dbg_pkg::*;

	// Requests from the debug module
	logic  req_halt;
	logic  req_resume;
	word_t data0_wdata;
	logic  data0_wen;

	// Status and data0 from the hart
	logic  halted;
	logic  running;
	word_t data0_rdata;

	modport dm (
		output req_halt,
		output req_resume,
		output data0_wdata,
		output data0_wen,
		input  halted,
		input  running,
		input  data0_rdata
	);

	modport hart (
		input  req_halt,
		input  req_resume,
		input  data0_wdata,
		input  data0_wen,
		output halted,
		output running,
		output data0_rdata
	);

endinterface

/* sba_if.sv */
// System bus access channel between the debug module and the SBA engine
`timescale 1ns/100ps

interface sba_if;
	import dbg_pkg::*;

	logic   start;
	logic   write;
	word_t  wdata;
	logic   addr_wen;
	word_t  addr_wdata;
	logic   autoinc;
	logic   err_clr;

	logic   busy;
	logic   done;
	word_t  rdata;
	word_t  addr;
	sberr_t sberror;

	modport dm (
		output start, write, wdata, addr_wen, addr_wdata, autoinc, err_clr,
		input  busy, done, rdata, addr, sberror
	);

	modport engine (
		input  start, write, wdata, addr_wen, addr_wdata, autoinc, err_clr,
		output busy, done, rdata, addr, sberror
	);

endinterface

/* dbg_reset_sync.sv */
// Hart reset synchroniser, asynchronous assert and two-cycle synchronous release
`timescale 1ns/100ps

module dbg_reset_sync (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_rst_req,
	output logic o_rst_n
);

	logic       rst_async_n;
	logic [1:0] sync_q;

	// Main reset or debug system reset
	assign rst_async_n = i_rst_n && !i_rst_req;

	always_ff @(posedge clk or negedge rst_async_n) begin
		if (!rst_async_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
		end
	end

	assign o_rst_n = sync_q[1];

endmodule

/* dbg_hart_agent.sv */
// Hart debug agent
// Halt/resume responder in place of a core's debug port, holds the hart's data0
`timescale 1ns/100ps

module dbg_hart_agent (
	input  logic     clk,
	input  logic     i_rst_n,
	hart_dbg_if.hart dbg
);
	import dbg_pkg::*;

	typedef enum logic {
		S_RUNNING,
		S_HALTED
	} state_t;

	state_t state;
	word_t  data0;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= S_RUNNING;
		end else begin
			case (state)
				S_RUNNING: begin
					if (dbg.req_halt) begin
						state <= S_HALTED;
					end
				end
				S_HALTED: begin
					if (dbg.req_resume) begin
						state <= S_RUNNING;
					end
				end
			endcase
		end
	end

	// Debug data register, writable only in debug mode
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			data0 <= '0;
		end else if (dbg.data0_wen && state == S_HALTED) begin
			data0 <= dbg.data0_wdata;
		end
	end

	// Neither running nor halted while held in reset
	assign dbg.halted      = (state == S_HALTED);
	assign dbg.running     = (state == S_RUNNING) && i_rst_n;
	assign dbg.data0_rdata = data0;

endmodule

/* dbg_sba_engine.sv */
// System bus access engine
// Single 32-bit transfers with address auto-increment and sticky bus error
`timescale 1ns/100ps

module dbg_sba_engine (
	input  logic           clk,
	input  logic           i_rst_n,
	sba_if.engine          sba,
	output dbg_pkg::word_t o_sbus_addr,
	output logic           o_sbus_write,
	output dbg_pkg::word_t o_sbus_wdata,
	output logic           o_sbus_vld,
	input  logic           i_sbus_rdy,
	input  logic           i_sbus_err,
	input  dbg_pkg::word_t i_sbus_rdata
);
	import dbg_pkg::*;

	word_t  addr_q;
	word_t  wdata_q;
	word_t  rdata_q;
	logic   write_q;
	logic   vld_q;
	logic   done_q;
	sberr_t err_q;
	logic   xfer_end;

	assign xfer_end = vld_q && i_sbus_rdy;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			vld_q  <= 1'b0;
			done_q <= 1'b0;
			err_q  <= '0;
		end else begin
			done_q <= 1'b0;
			if (sba.err_clr) begin
				err_q <= '0;
			end
			if (vld_q) begin
				if (i_sbus_rdy) begin
					vld_q  <= 1'b0;
					done_q <= 1'b1;
					if (i_sbus_err) begin
						err_q <= SBERR_BUS;
					end
				end
			end else if (sba.start) begin
				// Refused with an immediate done while an error is pending
				if (err_q != '0) begin
					done_q <= 1'b1;
				end else begin
					vld_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			addr_q <= '0;
		end else if (sba.addr_wen) begin
			addr_q <= sba.addr_wdata;
		end else if (xfer_end && !i_sbus_err && sba.autoinc) begin
			addr_q <= addr_q + word_t'(XLEN / 8);
		end
	end

	// Transfer payload, held stable while vld waits for rdy
	always_ff @(posedge clk) begin
		if (sba.start && !vld_q) begin
			write_q <= sba.write;
			wdata_q <= sba.wdata;
		end
		if (xfer_end && !write_q && !i_sbus_err) begin
			rdata_q <= i_sbus_rdata;
		end
	end

	assign o_sbus_addr  = addr_q;
	assign o_sbus_write = write_q;
	assign o_sbus_wdata = wdata_q;
	assign o_sbus_vld   = vld_q;

	assign sba.busy    = vld_q;
	assign sba.done    = done_q;
	assign sba.rdata   = rdata_q;
	assign sba.addr    = addr_q;
	assign sba.sberror = err_q;

endmodule

/* dbg_module.sv */
// RISC-V debug module
// DMI register decode, hart halt/resume control, system reset and bus access
`timescale 1ns/100ps

module dbg_module (
	input  logic               clk,
	input  logic               i_rst_n,
	input  logic               i_dmi_psel,
	input  logic               i_dmi_penable,
	input  logic               i_dmi_pwrite,
	input  dbg_pkg::dmi_addr_t i_dmi_paddr,
	input  dbg_pkg::word_t     i_dmi_pwdata,
	output dbg_pkg::word_t     o_dmi_prdata,
	output logic               o_dmi_pready,
	output logic               o_dmi_pslverr,
	hart_dbg_if.dm             hart [dbg_pkg::N_HARTS],
	sba_if.dm                  sba,
	output logic               o_ndmreset
);
	import dbg_pkg::*;

	logic               dmi_acc;
	logic               dmi_wr;
	logic               sb_xfer;
	logic               sb_pend;
	logic               haltreq;
	logic               resume_q;
	hart_sel_t          hartsel;
	logic               dmactive;
	logic               sb_autoinc;
	logic               sb_readondata;
	word_t              sb_rd_hold;
	logic [N_HARTS-1:0] hart_halted;
	logic [N_HARTS-1:0] hart_running;
	word_t              hart_data0 [N_HARTS];
	word_t              dmcontrol;
	word_t              dmstatus;
	word_t              sbcs;

	assign dmi_acc = i_dmi_psel && i_dmi_penable;
	assign dmi_wr  = dmi_acc && i_dmi_pwrite;

	// Requests go to the selected hart only
	for (genvar h = 0; h < N_HARTS; h++) begin : g_hart
		assign hart[h].req_halt    = haltreq && (hartsel == hart_sel_t'(h));
		assign hart[h].req_resume  = resume_q && (hartsel == hart_sel_t'(h));
		assign hart[h].data0_wdata = i_dmi_pwdata;
		assign hart[h].data0_wen   = dmi_wr && (i_dmi_paddr == ADDR_DATA0)
			&& (hartsel == hart_sel_t'(h));
		assign hart_halted[h]      = hart[h].halted;
		assign hart_running[h]     = hart[h].running;
		assign hart_data0[h]       = hart[h].data0_rdata;
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			haltreq       <= 1'b0;
			resume_q      <= 1'b0;
			hartsel       <= '0;
			o_ndmreset    <= 1'b0;
			dmactive      <= 1'b0;
			sb_autoinc    <= 1'b0;
			sb_readondata <= 1'b0;
			sb_pend       <= 1'b0;
		end else begin
			// resumereq is a pulse and reads back as 0
			resume_q <= 1'b0;
			if (dmi_wr && i_dmi_paddr == ADDR_DMCONTROL) begin
				haltreq    <= i_dmi_pwdata[DMC_HALTREQ];
				resume_q   <= i_dmi_pwdata[DMC_RESUMEREQ];
				hartsel    <= i_dmi_pwdata[DMC_HARTSEL +: $bits(hart_sel_t)];
				o_ndmreset <= i_dmi_pwdata[DMC_NDMRESET];
				dmactive   <= i_dmi_pwdata[DMC_DMACTIVE];
			end
			if (dmi_wr && i_dmi_paddr == ADDR_SBCS) begin
				sb_autoinc    <= i_dmi_pwdata[SBCS_AUTOINC];
				sb_readondata <= i_dmi_pwdata[SBCS_READONDATA];
			end
			if (sba.start) begin
				sb_pend <= 1'b1;
			end else if (sba.done) begin
				sb_pend <= 1'b0;
			end
		end
	end

	// Data from the previous read, returned while the next one runs
	always_ff @(posedge clk) begin
		if (sba.start) begin
			sb_rd_hold <= sba.rdata;
		end
	end

	// sbdata0 writes, and reads with readondata, launch a bus transfer
	assign sb_xfer = dmi_acc && (i_dmi_paddr == ADDR_SBDATA0)
		&& (i_dmi_pwrite || sb_readondata);

	assign sba.start      = sb_xfer && !sb_pend;
	assign sba.write      = i_dmi_pwrite;
	assign sba.wdata      = i_dmi_pwdata;
	assign sba.addr_wen   = dmi_wr && (i_dmi_paddr == ADDR_SBADDRESS0);
	assign sba.addr_wdata = i_dmi_pwdata;
	assign sba.autoinc    = sb_autoinc;
	assign sba.err_clr    = dmi_wr && (i_dmi_paddr == ADDR_SBCS)
		&& (|i_dmi_pwdata[SBCS_SBERROR +: $bits(sberr_t)]);

	assign o_dmi_pready  = !sb_xfer || sba.done;
	assign o_dmi_pslverr = sb_xfer && sba.done && (sba.sberror != '0);

	always_comb begin
		dmcontrol = '0;
		dmcontrol[DMC_HALTREQ]                        = haltreq;
		dmcontrol[DMC_HARTSEL +: $bits(hart_sel_t)]   = hartsel;
		dmcontrol[DMC_NDMRESET]                       = o_ndmreset;
		dmcontrol[DMC_DMACTIVE]                       = dmactive;

		// One hart selected at a time, so all and any agree
		dmstatus = '0;
		dmstatus[DMS_ALLRUNNING]                      = hart_running[hartsel];
		dmstatus[DMS_ANYRUNNING]                      = hart_running[hartsel];
		dmstatus[DMS_ALLHALTED]                       = hart_halted[hartsel];
		dmstatus[DMS_ANYHALTED]                       = hart_halted[hartsel];
		dmstatus[DMS_AUTHENTICATED]                   = 1'b1;
		dmstatus[DMS_VERSION +: $bits(DM_VERSION)]    = DM_VERSION;

		sbcs = '0;
		sbcs[SBCS_SBBUSY]                             = sba.busy;
		sbcs[SBCS_AUTOINC]                            = sb_autoinc;
		sbcs[SBCS_READONDATA]                         = sb_readondata;
		sbcs[SBCS_SBERROR +: $bits(sberr_t)]          = sba.sberror;
	end

	always_comb begin
		case (i_dmi_paddr)
			ADDR_DATA0:      o_dmi_prdata = hart_data0[hartsel];
			ADDR_DMCONTROL:  o_dmi_prdata = dmcontrol;
			ADDR_DMSTATUS:   o_dmi_prdata = dmstatus;
			ADDR_SBCS:       o_dmi_prdata = sbcs;
			ADDR_SBADDRESS0: o_dmi_prdata = sba.addr;
			ADDR_SBDATA0:    o_dmi_prdata = sb_pend ? sb_rd_hold : sba.rdata;
			default:         o_dmi_prdata = '0;
		endcase
	end

endmodule

/* dbg_subsys_top.sv */
// Debug subsystem top level
// Debug module with two hart agents, their reset synchronisers and the SBA engine
`timescale 1ns/100ps

module dbg_subsys_top (
	input  logic                        clk,
	input  logic                        i_rst_n,

	// DMI
	input  logic                        i_dmi_psel,
	input  logic                        i_dmi_penable,
	input  logic                        i_dmi_pwrite,
	input  dbg_pkg::dmi_addr_t          i_dmi_paddr,
	input  dbg_pkg::word_t              i_dmi_pwdata,
	output dbg_pkg::word_t              o_dmi_prdata,
	output logic                        o_dmi_pready,
	output logic                        o_dmi_pslverr,

	// System bus
	output dbg_pkg::word_t              o_sbus_addr,
	output logic                        o_sbus_write,
	output dbg_pkg::word_t              o_sbus_wdata,
	output logic                        o_sbus_vld,
	input  logic                        i_sbus_rdy,
	input  logic                        i_sbus_err,
	input  dbg_pkg::word_t              i_sbus_rdata,

	output logic [dbg_pkg::N_HARTS-1:0] o_hart_rst_n
);
	import dbg_pkg::*;

	logic ndmreset;

	hart_dbg_if hart_if [N_HARTS] ();
	sba_if      sba_bus ();

	dbg_module u_dm (
		.clk           (clk),
		.i_rst_n       (i_rst_n),
		.i_dmi_psel    (i_dmi_psel),
		.i_dmi_penable (i_dmi_penable),
		.i_dmi_pwrite  (i_dmi_pwrite),
		.i_dmi_paddr   (i_dmi_paddr),
		.i_dmi_pwdata  (i_dmi_pwdata),
		.o_dmi_prdata  (o_dmi_prdata),
		.o_dmi_pready  (o_dmi_pready),
		.o_dmi_pslverr (o_dmi_pslverr),
		.hart          (hart_if),
		.sba           (sba_bus),
		.o_ndmreset    (ndmreset)
	);

	for (genvar h = 0; h < N_HARTS; h++) begin : g_hart
		dbg_reset_sync u_rst_sync (
			.clk       (clk),
			.i_rst_n   (i_rst_n),
			.i_rst_req (ndmreset),
			.o_rst_n   (o_hart_rst_n[h])
		);

		dbg_hart_agent u_agent (
			.clk     (clk),
			.i_rst_n (o_hart_rst_n[h]),
			.dbg     (hart_if[h])
		);
	end

	dbg_sba_engine u_sba (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.sba          (sba_bus),
		.o_sbus_addr  (o_sbus_addr),
		.o_sbus_write (o_sbus_write),
		.o_sbus_wdata (o_sbus_wdata),
		.o_sbus_vld   (o_sbus_vld),
		.i_sbus_rdy   (i_sbus_rdy),
		.i_sbus_err   (i_sbus_err),
		.i_sbus_rdata (i_sbus_rdata)
	);

endmodule

/* dbg_subsys_properties.sv */
// Debug subsystem protocol properties
// DMI error timing, system bus stability and hart reset release
`timescale 1ns/100ps

module dbg_subsys_properties (
	input logic                        clk,
	input logic                        i_rst_n,
	input logic                        ndmreset,
	input logic                        i_dmi_psel,
	input logic                        i_dmi_penable,
	input logic                        o_dmi_pready,
	input logic                        o_dmi_pslverr,
	input logic                        o_sbus_vld,
	input logic                        i_sbus_rdy,
	input logic                        o_sbus_write,
	input dbg_pkg::word_t              o_sbus_addr,
	input dbg_pkg::word_t              o_sbus_wdata,
	input logic [dbg_pkg::N_HARTS-1:0] o_hart_rst_n
);

	int unsigned n_failures = 0;

	a_pslverr_in_access: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_dmi_pslverr |-> i_dmi_psel && i_dmi_penable && o_dmi_pready)
	else begin
		$error("pslverr high outside the completing access cycle");
		n_failures++;
	end

	// Held transfer keeps its address, direction and data until rdy
	a_sbus_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_sbus_vld && !i_sbus_rdy |=> o_sbus_vld && $stable(o_sbus_addr)
			&& $stable(o_sbus_wdata) && $stable(o_sbus_write))
	else begin
		$error("system bus request changed while waiting for rdy");
		n_failures++;
	end

	// Two release cycles, then every hart is out of reset
	a_hart_reset_release: assert property (@(posedge clk)
		(i_rst_n && !ndmreset) [*3] |-> &o_hart_rst_n)
	else begin
		$error("hart reset still low after its release window");
		n_failures++;
	end

endmodule

bind dbg_subsys_top dbg_subsys_properties u_props (
	.clk           (clk),
	.i_rst_n       (i_rst_n),
	.ndmreset      (ndmreset),
	.i_dmi_psel    (i_dmi_psel),
	.i_dmi_penable (i_dmi_penable),
	.o_dmi_pready  (o_dmi_pready),
	.o_dmi_pslverr (o_dmi_pslverr),
	.o_sbus_vld    (o_sbus_vld),
	.i_sbus_rdy    (i_sbus_rdy),
	.o_sbus_write  (o_sbus_write),
	.o_sbus_addr   (o_sbus_addr),
	.o_sbus_wdata  (o_sbus_wdata),
	.o_hart_rst_n  (o_hart_rst_n)
);

/* tb_dbg_subsys.sv */
// Debug subsystem testbench
// DMI driver, system bus memory model and a reference model of the debug registers
`timescale 1ns/100ps

module tb_dbg_subsys;
	import dbg_pkg::*;

	localparam int    DMI_TIMEOUT = 200;
	localparam int    POLL_LIMIT  = 20;
	localparam word_t MEM_BASE    = 32'h8000_0000;
	localparam word_t ERR_BASE    = 32'hDEAD_0000;

	logic               clk;
	logic               i_rst_n;
	logic               i_dmi_psel;
	logic               i_dmi_penable;
	logic               i_dmi_pwrite;
	dmi_addr_t          i_dmi_paddr;
	word_t              i_dmi_pwdata;
	word_t              o_dmi_prdata;
	logic               o_dmi_pready;
	logic               o_dmi_pslverr;
	word_t              o_sbus_addr;
	logic               o_sbus_write;
	word_t              o_sbus_wdata;
	logic               o_sbus_vld;
	logic               i_sbus_rdy;
	logic               i_sbus_err;
	word_t              i_sbus_rdata;
	logic [N_HARTS-1:0] o_hart_rst_n;

	word_t mem [16];
	word_t stall_seed = 32'd54105;
	word_t rnd;

	// Reference state of the debug module, the harts and the memory
	hart_sel_t          m_hartsel    = '0;
	logic [N_HARTS-1:0] m_halted     = '0;
	logic               m_in_reset   = 1'b0;
	word_t              m_data0 [N_HARTS] = '{default: '0};
	logic               m_autoinc    = 1'b0;
	logic               m_rdon       = 1'b0;
	sberr_t             m_sberr      = '0;
	word_t              m_sbaddr     = '0;
	word_t              m_last_rd    = '0;
	logic               m_last_valid = 1'b0;
	word_t              ref_mem [16];

	word_t got_q[$];
	word_t exp_q[$];
	string name_q[$];

	dbg_subsys_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic word_t lcg_step(word_t s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic in_err_range(word_t a);
		return a[31:16] == ERR_BASE[31:16];
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("ERROR t=%0t %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_error($sformatf("ERROR t=%0t %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	function automatic word_t dmcontrol_word(logic haltreq, logic resumereq, int sel,
			logic ndmreset);
		word_t w;
		w = '0;
		w[DMC_HALTREQ]   = haltreq;
		w[DMC_RESUMEREQ] = resumereq;
		w[DMC_HARTSEL]   = sel[0];
		w[DMC_NDMRESET]  = ndmreset;
		w[DMC_DMACTIVE]  = 1'b1;
		return w;
	endfunction

	function automatic word_t sbcs_word(logic autoinc, logic rdon, logic clr_err);
		word_t w;
		w = '0;
		w[SBCS_AUTOINC]    = autoinc;
		w[SBCS_READONDATA] = rdon;
		w[SBCS_SBERROR +: 3] = clr_err ? 3'b111 : 3'b000;
		return w;
	endfunction

	// One bus transfer as the engine should perform it
	function automatic void bus_transfer_model(logic write, word_t d);
		if (m_sberr == '0) begin
			if (in_err_range(m_sbaddr)) begin
				m_sberr = SBERR_BUS;
			end else begin
				if (write) begin
					ref_mem[m_sbaddr[5:2]] = d;
				end else begin
					m_last_rd    = ref_mem[m_sbaddr[5:2]];
					m_last_valid = 1'b1;
				end
				if (m_autoinc) begin
					m_sbaddr = m_sbaddr + 32'd4;
				end
			end
		end
	endfunction

	// Returns the expected pslverr of the write
	function automatic logic apply_write(dmi_addr_t addr, word_t d);
		logic err_out;
		err_out = 1'b0;
		case (addr)
			ADDR_DMCONTROL: begin
				m_hartsel = hart_sel_t'(d[DMC_HARTSEL]);
				if (d[DMC_NDMRESET]) begin
					m_in_reset = 1'b1;
					m_halted   = '0;
					for (int h = 0; h < N_HARTS; h++) begin
						m_data0[h] = '0;
					end
				end else begin
					m_in_reset = 1'b0;
					if (d[DMC_HALTREQ]) begin
						m_halted[m_hartsel] = 1'b1;
					end else if (d[DMC_RESUMEREQ]) begin
						m_halted[m_hartsel] = 1'b0;
					end
				end
			end
			ADDR_DATA0: begin
				if (!m_in_reset && m_halted[m_hartsel]) begin
					m_data0[m_hartsel] = d;
				end
			end
			ADDR_SBCS: begin
				m_autoinc = d[SBCS_AUTOINC];
				m_rdon    = d[SBCS_READONDATA];
				if (d[SBCS_SBERROR +: 3] != 3'b000) begin
					m_sberr = '0;
				end
			end
			ADDR_SBADDRESS0: m_sbaddr = d;
			ADDR_SBDATA0: begin
				bus_transfer_model(1'b1, d);
				err_out = (m_sberr != '0);
			end
			default: ;
		endcase
		return err_out;
	endfunction

	// Expected DMI read data from the reference state
	function automatic word_t ref_read(dmi_addr_t addr);
		word_t v;
		logic  run;
		logic  hlt;
		v   = '0;
		hlt = !m_in_reset && m_halted[m_hartsel];
		run = !m_in_reset && !m_halted[m_hartsel];
		case (addr)
			ADDR_DMSTATUS: begin
				v[DMS_ALLRUNNING]    = run;
				v[DMS_ANYRUNNING]    = run;
				v[DMS_ALLHALTED]     = hlt;
				v[DMS_ANYHALTED]     = hlt;
				v[DMS_AUTHENTICATED] = 1'b1;
				v[DMS_VERSION +: 4]  = DM_VERSION;
			end
			ADDR_DATA0: v = m_data0[m_hartsel];
			ADDR_SBCS: begin
				v[SBCS_AUTOINC]      = m_autoinc;
				v[SBCS_READONDATA]   = m_rdon;
				v[SBCS_SBERROR +: 3] = m_sberr;
			end
			ADDR_SBADDRESS0: v = m_sbaddr;
			ADDR_SBDATA0: v = m_last_rd;
			default: v = '0;
		endcase
		return v;
	endfunction

	// APB setup and access phases, then wait for pready
	task automatic dmi_transfer(input logic write, input dmi_addr_t addr, input word_t wdata,
			output word_t rdata, output logic slverr);
		int n;
		n = 0;
		@(negedge clk);
		i_dmi_psel    = 1'b1;
		i_dmi_penable = 1'b0;
		i_dmi_pwrite  = write;
		i_dmi_paddr   = addr;
		i_dmi_pwdata  = wdata;
		@(negedge clk);
		i_dmi_penable = 1'b1;
		@(posedge clk);
		while (!o_dmi_pready) begin
			if (n >= DMI_TIMEOUT) begin
				stop_with_error($sformatf("DMI access to %h never completed", addr));
			end
			n++;
			@(posedge clk);
		end
		rdata  = o_dmi_prdata;
		slverr = o_dmi_pslverr;
		@(negedge clk);
		i_dmi_psel    = 1'b0;
		i_dmi_penable = 1'b0;
	endtask

	task automatic dmi_write(input dmi_addr_t addr, input word_t data);
		word_t rd;
		logic  err;
		logic  exp_err;
		exp_err = apply_write(addr, data);
		dmi_transfer(1'b1, addr, data, rd, err);
		check_bit($sformatf("o_dmi_pslverr write %h", addr), err, exp_err);
	endtask

	task automatic dmi_read(input dmi_addr_t addr, input string name);
		word_t rd;
		word_t exp;
		logic  err;
		logic  exp_err;
		logic  valid;
		exp     = ref_read(addr);
		valid   = (addr != ADDR_SBDATA0) || m_last_valid;
		exp_err = 1'b0;
		if (addr == ADDR_SBDATA0 && m_rdon) begin
			bus_transfer_model(1'b0, '0);
			exp_err = (m_sberr != '0);
		end
		dmi_transfer(1'b0, addr, '0, rd, err);
		check_bit({name, " pslverr"}, err, exp_err);
		if (valid) begin
			got_q.push_back(rd);
			exp_q.push_back(exp);
			name_q.push_back(name);
		end
	endtask

	task automatic poll_status(input int bit_pos);
		word_t rd;
		logic  err;
		int    n;
		n = 0;
		dmi_transfer(1'b0, ADDR_DMSTATUS, '0, rd, err);
		while (!rd[bit_pos]) begin
			if (n >= POLL_LIMIT) begin
				stop_with_error($sformatf("dmstatus bit %0d never set", bit_pos));
			end
			n++;
			dmi_transfer(1'b0, ADDR_DMSTATUS, '0, rd, err);
		end
	endtask

	task automatic compare_memory();
		for (int i = 0; i < 16; i++) begin
			check_word($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
		end
	endtask

	// Every DMI read result against its reference value
	always @(negedge clk) begin
		while (got_q.size() > 0) begin
			check_word(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
		end
		if (u_dut.u_props.n_failures != 0) begin
			stop_with_error("A concurrent assertion on the DUT failed");
		end
	end

	// System bus memory with random rdy stalls
	always @(negedge clk) begin
		i_sbus_rdy = 1'b0;
		i_sbus_err = 1'b0;
		if (o_sbus_vld) begin
			stall_seed   = lcg_step(stall_seed);
			rnd          = stall_seed;
			i_sbus_rdy   = (rnd[18:16] < 3'd3);
			i_sbus_err   = in_err_range(o_sbus_addr);
			i_sbus_rdata = mem[o_sbus_addr[5:2]];
			if (i_sbus_rdy && o_sbus_write && !i_sbus_err) begin
				mem[o_sbus_addr[5:2]] = o_sbus_wdata;
			end
		end
	end

	initial begin
		i_rst_n       = 1'b0;
		i_dmi_psel    = 1'b0;
		i_dmi_penable = 1'b0;
		i_dmi_pwrite  = 1'b0;
		i_dmi_paddr   = '0;
		i_dmi_pwdata  = '0;
		i_sbus_rdy    = 1'b0;
		i_sbus_err    = 1'b0;
		i_sbus_rdata  = '0;
		for (int i = 0; i < 16; i++) begin
			mem[i]     = (MEM_BASE + word_t'(4 * i)) ^ 32'h5A5A_5A5A;
			ref_mem[i] = mem[i];
		end
		repeat (8) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;

		// Status after reset for each hart
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 0, 0, 0));
		dmi_read(ADDR_DMSTATUS, "dmstatus hart0 after reset");
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 0, 1, 0));
		dmi_read(ADDR_DMSTATUS, "dmstatus hart1 after reset");

		// Halt hart 1 while hart 0 keeps running
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(1, 0, 1, 0));
		poll_status(DMS_ALLHALTED);
		dmi_read(ADDR_DMSTATUS, "dmstatus hart1 halted");
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 0, 0, 0));
		dmi_read(ADDR_DMSTATUS, "dmstatus hart0 running");
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 1, 1, 0));
		dmi_read(ADDR_DMSTATUS, "dmstatus hart1 resumed");

		// data0 per hart, writable only while halted
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(1, 0, 0, 0));
		poll_status(DMS_ALLHALTED);
		dmi_write(ADDR_DATA0, 32'h1234_5678);
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(1, 0, 1, 0));
		poll_status(DMS_ALLHALTED);
		dmi_write(ADDR_DATA0, 32'h9ABC_DEF0);
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 0, 0, 0));
		dmi_read(ADDR_DATA0, "data0 hart0");
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 0, 1, 0));
		dmi_read(ADDR_DATA0, "data0 hart1");
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 1, 1, 0));
		dmi_write(ADDR_DATA0, 32'hDEAD_BEEF);
		dmi_read(ADDR_DATA0, "data0 hart1 after running write");
		dmi_read(ADDR_DMSTATUS, "dmstatus hart1 running");

		// Auto-incrementing writes and reads with readondata
		dmi_write(ADDR_SBCS, sbcs_word(1, 0, 0));
		dmi_write(ADDR_SBADDRESS0, MEM_BASE + 32'd8);
		for (int i = 0; i < 4; i++) begin
			dmi_write(ADDR_SBDATA0, 32'hC0DE_0000 | word_t'(i * 32'h111));
		end
		dmi_read(ADDR_SBADDRESS0, "sbaddress0 after writes");
		compare_memory();
		dmi_write(ADDR_SBADDRESS0, MEM_BASE + 32'd8);
		dmi_write(ADDR_SBCS, sbcs_word(1, 1, 0));
		for (int i = 0; i < 4; i++) begin
			dmi_read(ADDR_SBDATA0, $sformatf("sbdata0 read %0d", i));
		end
		dmi_write(ADDR_SBCS, sbcs_word(1, 0, 0));
		dmi_read(ADDR_SBDATA0, "sbdata0 last read");
		dmi_read(ADDR_SBCS, "sbcs after reads");

		// Bus error, refused transfer, error clear
		dmi_write(ADDR_SBADDRESS0, ERR_BASE);
		dmi_write(ADDR_SBDATA0, 32'h0BAD_0001);
		dmi_read(ADDR_SBCS, "sbcs after bus error");
		dmi_write(ADDR_SBADDRESS0, MEM_BASE);
		dmi_write(ADDR_SBDATA0, 32'h0BAD_0002);
		dmi_read(ADDR_SBDATA0, "sbdata0 while error");
		compare_memory();
		dmi_write(ADDR_SBCS, sbcs_word(1, 0, 1));
		dmi_read(ADDR_SBCS, "sbcs after clear");
		dmi_write(ADDR_SBDATA0, 32'h600D_600D);
		compare_memory();

		// Debug system reset of both harts
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 0, 1, 1));
		check_bit("o_hart_rst_n[0]", o_hart_rst_n[0], 1'b0);
		check_bit("o_hart_rst_n[1]", o_hart_rst_n[1], 1'b0);
		dmi_read(ADDR_DMSTATUS, "dmstatus during ndmreset");
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 0, 1, 0));
		poll_status(DMS_ANYRUNNING);
		dmi_read(ADDR_DMSTATUS, "dmstatus hart1 after ndmreset");
		dmi_read(ADDR_DATA0, "data0 hart1 after ndmreset");
		dmi_write(ADDR_DMCONTROL, dmcontrol_word(0, 0, 0, 0));
		poll_status(DMS_ANYRUNNING);
		dmi_read(ADDR_DMSTATUS, "dmstatus hart0 after ndmreset");
		dmi_read(ADDR_DATA0, "data0 hart0 after ndmreset");
		check_bit("o_hart_rst_n[0]", o_hart_rst_n[0], 1'b1);
		check_bit("o_hart_rst_n[1]", o_hart_rst_n[1], 1'b1);

		repeat (2) @(negedge clk);
		if (u_dut.u_props.n_failures == 0 && got_q.size() == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			stop_with_error("Read results left unchecked or assertions failed at the end");
		end
	end

endmodule

/* all.f */
dbg_pkg.sv
hart_dbg_if.sv
sba_if.sv
dbg_reset_sync.sv
dbg_hart_agent.sv
dbg_sba_engine.sv
dbg_module.sv
dbg_subsys_top.sv
dbg_subsys_properties.sv
tb_dbg_subsys.sv
